//--- build.f
logic/udp_pkg.sv
logic/udp_ingress_buffer.sv
logic/udp_decode.sv
logic/udp_execute.sv
logic/udp_result.sv
logic/udp_echo_core.sv
sim/tb_clock_gen.sv
sim/udp_echo_asserts.sv
sim/udp_echo_tb.sv

//--- Makefile
# Verilator simulation of the UDP echo core

VERILATOR ?= verilator
TOP       ?= udp_echo_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation PASSED

.PHONY: sim clean

# Status comes from grep, so a run without the pass line fails
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- sim/udp_echo_tb.sv
`timescale 1ns/1ns

module udp_echo_tb import udp_pkg::*; ;

    localparam udp_port_t  ECHO_DST   = 16'd1234;
    localparam ipv4_addr_t LOCAL_ADDR = 32'hc0a8_0180;
    localparam int         GRANT_PCT  = 50;

    typedef struct packed {
        logic       is_echo;
        ipv4_addr_t src_ip;
        ipv4_addr_t dst_ip;
        udp_port_t  src_port;
        udp_port_t  dst_port;
        udp_len_t   length;
    } hdr_t;

    typedef struct packed {
        hdr_t  hdr;
        data_t data;
        keep_t keep;
        logic  last;
    } beat_t;

    logic clk;
    logic rst;
    ipv4_addr_t local_ip;
    logic in_valid, in_last, in_credit;
    data_t in_data;
    keep_t in_keep;
    ipv4_addr_t in_src_ip, in_dst_ip;
    udp_port_t in_src_port, in_dst_port;
    udp_len_t in_length;
    logic echo_valid, echo_last, echo_credit;
    data_t echo_data;
    keep_t echo_keep;
    ipv4_addr_t echo_src_ip, echo_dst_ip;
    udp_port_t echo_src_port, echo_dst_port;
    udp_len_t echo_length;
    logic usr_valid, usr_last, usr_credit;
    data_t usr_data;
    keep_t usr_keep;
    ipv4_addr_t usr_src_ip, usr_dst_ip;
    udp_port_t usr_src_port, usr_dst_port;
    udp_len_t usr_length;
    logic [7:0] led;

    integer seed = 32'h28e2;
    beat_t tx_q[$];
    beat_t echo_q[$];
    beat_t usr_q[$];
    beat_t tx_beat, got_beat, exp_beat;
    int beats_in, credit_back;
    int echo_sent, usr_sent, echo_granted, usr_granted;
    bit echo_grant_on, usr_grant_on;
    bit echo_first_beat = 1'b1;
    logic [7:0] exp_led = 8'h00;
    int mark, i, n;

    tb_clock_gen i_clock (.clk(clk));

    udp_echo_core i_dut (.*);

    task automatic abort_run(input string reason);
        $display("ERROR at %0t ns: %s", $time, reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // Outgoing header and route as the core should produce them
    function automatic hdr_t expected_header(input hdr_t h, input ipv4_addr_t local_addr);
        hdr_t r;
        r = h;
        r.is_echo = (h.dst_port == ECHO_DST);
        if (r.is_echo) begin
            r.src_ip   = local_addr;
            r.dst_ip   = h.src_ip;
            r.src_port = h.dst_port;
            r.dst_port = h.src_port;
        end
        return r;
    endfunction

    task automatic queue_frame(input bit to_echo, input int nbeats);
        hdr_t h;
        hdr_t exp_h;
        beat_t b;
        h.is_echo  = 1'b0;
        h.src_ip   = $random(seed);
        h.dst_ip   = $random(seed);
        h.src_port = $random(seed);
        h.dst_port = to_echo ? ECHO_DST : udp_port_t'($random(seed));
        if (!to_echo && h.dst_port == ECHO_DST) begin
            h.dst_port = h.dst_port + 1'b1;
        end
        h.length = udp_len_t'(8 + 8 * nbeats);
        exp_h = expected_header(h, LOCAL_ADDR);
        for (int k = 0; k < nbeats; k++) begin
            b.data = {$random(seed), $random(seed)};
            b.last = (k == nbeats - 1);
            // Partial keep only on the last beat
            b.keep = b.last ? (8'hff >> ($unsigned($random(seed)) % 8)) : 8'hff;
            b.hdr  = h;
            tx_q.push_back(b);
            b.hdr = exp_h;
            if (exp_h.is_echo) begin
                echo_q.push_back(b);
            end else begin
                usr_q.push_back(b);
            end
        end
    endtask

    task automatic compare_beat(input string port, input beat_t got, input beat_t exp);
        check({port, "_data"}, got.data, exp.data);
        check({port, "_keep"}, got.keep, exp.keep);
        check({port, "_last"}, got.last, exp.last);
        check({port, "_src_ip"}, got.hdr.src_ip, exp.hdr.src_ip);
        check({port, "_dst_ip"}, got.hdr.dst_ip, exp.hdr.dst_ip);
        check({port, "_src_port"}, got.hdr.src_port, exp.hdr.src_port);
        check({port, "_dst_port"}, got.hdr.dst_port, exp.hdr.dst_port);
        check({port, "_length"}, got.hdr.length, exp.hdr.length);
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (tx_q.size() != 0 || echo_q.size() != 0 || usr_q.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                abort_run("timeout while waiting for all frames to leave the core");
            end
        end
    endtask

    // Upstream side, spends one credit per beat
    initial begin
        in_valid = 1'b0;
        in_data = '0;
        in_keep = '0;
        in_last = 1'b0;
        in_src_ip = '0;
        in_dst_ip = '0;
        in_src_port = '0;
        in_dst_port = '0;
        in_length = '0;
        forever begin
            @(negedge clk);
            if (!rst && tx_q.size() > 0 && beats_in - credit_back < IN_CREDITS) begin
                tx_beat = tx_q.pop_front();
                in_valid = 1'b1;
                in_data = tx_beat.data;
                in_keep = tx_beat.keep;
                in_last = tx_beat.last;
                in_src_ip = tx_beat.hdr.src_ip;
                in_dst_ip = tx_beat.hdr.dst_ip;
                in_src_port = tx_beat.hdr.src_port;
                in_dst_port = tx_beat.hdr.dst_port;
                in_length = tx_beat.hdr.length;
                beats_in++;
            end else begin
                in_valid = 1'b0;
            end
        end
    end

    // Downstream credits at random times, never more than 15 outstanding
    initial begin
        echo_credit = 1'b0;
        usr_credit = 1'b0;
        forever begin
            @(negedge clk);
            echo_credit = 1'b0;
            usr_credit = 1'b0;
            if (!rst && echo_grant_on && echo_granted - echo_sent < 15
                    && ($unsigned($random(seed)) % 100) < GRANT_PCT) begin
                echo_credit = 1'b1;
                echo_granted++;
            end
            if (!rst && usr_grant_on && usr_granted - usr_sent < 15
                    && ($unsigned($random(seed)) % 100) < GRANT_PCT) begin
                usr_credit = 1'b1;
                usr_granted++;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            // Value before this edge, so it reflects earlier echo frames only
            check("led", led, exp_led);
            if (in_credit) begin
                credit_back++;
            end
            if (echo_valid && usr_valid) begin
                abort_run("echo and user ports sent a beat in the same cycle");
            end
            if (echo_valid) begin
                got_beat = {1'b1, echo_src_ip, echo_dst_ip, echo_src_port, echo_dst_port,
                            echo_length, echo_data, echo_keep, echo_last};
                if (echo_q.size() == 0) begin
                    abort_run("beat on the echo port while no echo frame was expected");
                end else begin
                    exp_beat = echo_q.pop_front();
                    compare_beat("echo", got_beat, exp_beat);
                    echo_sent++;
                    check("echo beats within credits", echo_sent <= echo_granted, 1);
                    if (echo_first_beat) begin
                        exp_led = exp_beat.data[7:0];
                    end
                    echo_first_beat = exp_beat.last;
                end
            end
            if (usr_valid) begin
                got_beat = {1'b0, usr_src_ip, usr_dst_ip, usr_src_port, usr_dst_port,
                            usr_length, usr_data, usr_keep, usr_last};
                if (usr_q.size() == 0) begin
                    abort_run("beat on the user port while no user frame was expected");
                end else begin
                    exp_beat = usr_q.pop_front();
                    compare_beat("usr", got_beat, exp_beat);
                    usr_sent++;
                    check("usr beats within credits", usr_sent <= usr_granted, 1);
                end
            end
        end
    end

    initial begin
        rst = 1'b1;
        local_ip = LOCAL_ADDR;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // Idle core stays quiet
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            check("echo_valid", echo_valid, 0);
            check("usr_valid", usr_valid, 0);
            check("in_credit", in_credit, 0);
            check("led", led, 0);
        end

        // No output credits yet, so the echo frame must back up
        queue_frame(1'b1, 8);
        for (i = 0; i < 40; i++) begin
            @(negedge clk);
            if (echo_valid || usr_valid) begin
                abort_run("output beat appeared before any credit was granted");
            end
            if (i == 20) begin
                mark = credit_back;
            end
        end
        check("in_credit pulses while stalled", credit_back, mark);
        check("upstream ran out of credits", beats_in < 8, 1);

        echo_grant_on = 1'b1;
        usr_grant_on = 1'b1;
        wait_drain(400);
        queue_frame(1'b0, 3);
        wait_drain(400);
        queue_frame(1'b1, 1);
        wait_drain(400);

        // Random mix of frames
        for (n = 0; n < 40; n++) begin
            queue_frame($random(seed) & 1, 1 + $unsigned($random(seed)) % 6);
        end
        wait_drain(8000);

        check("in_credit pulses", credit_back, beats_in);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- sim/udp_echo_asserts.sv
`timescale 1ns/1ns

module udp_echo_asserts import udp_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  echo_valid,
    input logic  usr_valid,
    input keep_t echo_keep,
    input keep_t usr_keep,
    input logic  echo_credit,
    input logic  usr_credit
);

    // Credits granted and not yet spent, counted from the port pulses
    int echo_avail;
    int usr_avail;

    always_ff @(posedge clk) begin
        if (rst) begin
            echo_avail <= 0;
            usr_avail  <= 0;
        end else begin
            echo_avail <= echo_avail + int'(echo_credit) - int'(echo_valid);
            usr_avail  <= usr_avail + int'(usr_credit) - int'(usr_valid);
        end
    end

    // Outputs quiet in every cycle that follows a reset edge
    a_quiet_in_reset: assert property (@(posedge clk) rst |=> !echo_valid && !usr_valid)
        else $error("output valid during reset");

    a_one_port: assert property (@(posedge clk) disable iff (rst) !(echo_valid && usr_valid))
        else $error("echo_valid and usr_valid high together");

    a_echo_keep: assert property (@(posedge clk) disable iff (rst) echo_valid |-> echo_keep != '0)
        else $error("echo beat with empty keep");

    a_usr_keep: assert property (@(posedge clk) disable iff (rst) usr_valid |-> usr_keep != '0)
        else $error("user beat with empty keep");

    // A beat needs a credit on its own port
    a_echo_credit: assert property (@(posedge clk) disable iff (rst) echo_valid |-> echo_avail != 0)
        else $error("echo beat sent without credit");

    a_usr_credit: assert property (@(posedge clk) disable iff (rst) usr_valid |-> usr_avail != 0)
        else $error("user beat sent without credit");

endmodule

bind udp_result udp_echo_asserts i_asserts (.*);

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk
);

    // 20 ns period
    localparam int HALF_PERIOD = 10;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

//--- logic/udp_echo_core.sv
`timescale 1ns/1ns

module udp_echo_core import udp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  ipv4_addr_t local_ip,

    // Parsed UDP frames from the stack
    input  logic       in_valid,
    input  data_t      in_data,
    input  keep_t      in_keep,
    input  logic       in_last,
    input  ipv4_addr_t in_src_ip,
    input  ipv4_addr_t in_dst_ip,
    input  udp_port_t  in_src_port,
    input  udp_port_t  in_dst_port,
    input  udp_len_t   in_length,
    output logic       in_credit,

    // Echo responses
    output logic       echo_valid,
    output data_t      echo_data,
    output keep_t      echo_keep,
    output logic       echo_last,
    output ipv4_addr_t echo_src_ip,
    output ipv4_addr_t echo_dst_ip,
    output udp_port_t  echo_src_port,
    output udp_port_t  echo_dst_port,
    output udp_len_t   echo_length,
    input  logic       echo_credit,

    // Frames for the user pipeline
    output logic       usr_valid,
    output data_t      usr_data,
    output keep_t      usr_keep,
    output logic       usr_last,
    output ipv4_addr_t usr_src_ip,
    output ipv4_addr_t usr_dst_ip,
    output udp_port_t  usr_src_port,
    output udp_port_t  usr_dst_port,
    output udp_len_t   usr_length,
    input  logic       usr_credit,

    output logic [7:0] led
);

    // Buffer to decode
    logic       buf_valid;
    data_t      buf_data;
    keep_t      buf_keep;
    logic       buf_last;
    ipv4_addr_t buf_src_ip;
    ipv4_addr_t buf_dst_ip;
    udp_port_t  buf_src_port;
    udp_port_t  buf_dst_port;
    udp_len_t   buf_length;
    logic       stall;

    // Decode to execute
    logic       dec_valid;
    data_t      dec_data;
    keep_t      dec_keep;
    logic       dec_last;
    route_t     dec_route;
    ipv4_addr_t dec_src_ip;
    ipv4_addr_t dec_dst_ip;
    udp_port_t  dec_src_port;
    udp_port_t  dec_dst_port;
    udp_len_t   dec_length;
    logic       exe_stall;

    // Execute to result
    logic       exe_valid;
    data_t      exe_data;
    keep_t      exe_keep;
    logic       exe_last;
    route_t     exe_route;
    ipv4_addr_t exe_src_ip;
    ipv4_addr_t exe_dst_ip;
    udp_port_t  exe_src_port;
    udp_port_t  exe_dst_port;
    udp_len_t   exe_length;
    logic       res_stall;

    // Stage ports share names with the nets above
    udp_ingress_buffer i_buffer (.*);
    udp_decode         i_decode (.*);
    udp_execute        i_execute (.*);
    udp_result         i_result (.*);

endmodule

//--- logic/udp_result.sv
`timescale 1ns/1ns

module udp_result import udp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       exe_valid,
    input  data_t      exe_data,
    input  keep_t      exe_keep,
    input  logic       exe_last,
    input  route_t     exe_route,
    input  ipv4_addr_t exe_src_ip,
    input  ipv4_addr_t exe_dst_ip,
    input  udp_port_t  exe_src_port,
    input  udp_port_t  exe_dst_port,
    input  udp_len_t   exe_length,
    output logic       res_stall,
    input  logic       echo_credit,
    input  logic       usr_credit,
    output logic       echo_valid,
    output data_t      echo_data,
    output keep_t      echo_keep,
    output logic       echo_last,
    output ipv4_addr_t echo_src_ip,
    output ipv4_addr_t echo_dst_ip,
    output udp_port_t  echo_src_port,
    output udp_port_t  echo_dst_port,
    output udp_len_t   echo_length,
    output logic       usr_valid,
    output data_t      usr_data,
    output keep_t      usr_keep,
    output logic       usr_last,
    output ipv4_addr_t usr_src_ip,
    output ipv4_addr_t usr_dst_ip,
    output udp_port_t  usr_src_port,
    output udp_port_t  usr_dst_port,
    output udp_len_t   usr_length,
    output logic [7:0] led
);

    logic [CREDIT_W-1:0] echo_cnt;
    logic [CREDIT_W-1:0] usr_cnt;
    logic                echo_first;

    // Credit pulse adds one, a sent beat takes one
    function automatic logic [CREDIT_W-1:0] next_count(
        input logic [CREDIT_W-1:0] count,
        input logic                grant,
        input logic                spend
    );
        logic [CREDIT_W-1:0] result;
        result = count;
        if (grant && !spend) begin
            result = count + 1'b1;
        end else if (!grant && spend) begin
            result = count - 1'b1;
        end
        return result;
    endfunction

    // Send straight from the execute register when the route has credit
    assign echo_valid = exe_valid && (exe_route == ROUTE_ECHO) && (echo_cnt != '0);
    assign usr_valid  = exe_valid && (exe_route == ROUTE_USER) && (usr_cnt != '0);
    assign res_stall  = exe_valid && !(echo_valid || usr_valid);

    // Both ports see the same beat, only the valid differs
    assign echo_data     = exe_data;
    assign echo_keep     = exe_keep;
    assign echo_last     = exe_last;
    assign echo_src_ip   = exe_src_ip;
    assign echo_dst_ip   = exe_dst_ip;
    assign echo_src_port = exe_src_port;
    assign echo_dst_port = exe_dst_port;
    assign echo_length   = exe_length;

    assign usr_data     = exe_data;
    assign usr_keep     = exe_keep;
    assign usr_last     = exe_last;
    assign usr_src_ip   = exe_src_ip;
    assign usr_dst_ip   = exe_dst_ip;
    assign usr_src_port = exe_src_port;
    assign usr_dst_port = exe_dst_port;
    assign usr_length   = exe_length;

    always_ff @(posedge clk) begin
        if (rst) begin
            echo_cnt   <= '0;
            usr_cnt    <= '0;
            echo_first <= 1'b1;
            led        <= 8'h00;
        end else begin
            echo_cnt <= next_count(echo_cnt, echo_credit, echo_valid);
            usr_cnt  <= next_count(usr_cnt, usr_credit, usr_valid);
            if (echo_valid) begin
                echo_first <= echo_last;
                // First payload byte of each response
                if (echo_first) begin
                    led <= exe_data[7:0];
                end
            end
        end
    end

endmodule

//--- logic/udp_execute.sv
`timescale 1ns/1ns

module udp_execute import udp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  ipv4_addr_t local_ip,
    input  logic       dec_valid,
    input  data_t      dec_data,
    input  keep_t      dec_keep,
    input  logic       dec_last,
    input  route_t     dec_route,
    input  ipv4_addr_t dec_src_ip,
    input  ipv4_addr_t dec_dst_ip,
    input  udp_port_t  dec_src_port,
    input  udp_port_t  dec_dst_port,
    input  udp_len_t   dec_length,
    output logic       exe_stall,
    output logic       exe_valid,
    output data_t      exe_data,
    output keep_t      exe_keep,
    output logic       exe_last,
    output route_t     exe_route,
    output ipv4_addr_t exe_src_ip,
    output ipv4_addr_t exe_dst_ip,
    output udp_port_t  exe_src_port,
    output udp_port_t  exe_dst_port,
    output udp_len_t   exe_length,
    input  logic       res_stall
);

    logic take;

    assign exe_stall = exe_valid && res_stall;
    assign take      = dec_valid && !exe_stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_valid <= 1'b0;
        end else if (!exe_stall) begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            exe_data   <= dec_data;
            exe_keep   <= dec_keep;
            exe_last   <= dec_last;
            exe_route  <= dec_route;
            exe_length <= dec_length;
            if (dec_route == ROUTE_ECHO) begin
                // Response goes back to the sender with ports swapped
                exe_src_ip   <= local_ip;
                exe_dst_ip   <= dec_src_ip;
                exe_src_port <= dec_dst_port;
                exe_dst_port <= dec_src_port;
            end else begin
                exe_src_ip   <= dec_src_ip;
                exe_dst_ip   <= dec_dst_ip;
                exe_src_port <= dec_src_port;
                exe_dst_port <= dec_dst_port;
            end
        end
    end

endmodule

//--- logic/udp_decode.sv
`timescale 1ns/1ns

module udp_decode import udp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       buf_valid,
    input  data_t      buf_data,
    input  keep_t      buf_keep,
    input  logic       buf_last,
    input  ipv4_addr_t buf_src_ip,
    input  ipv4_addr_t buf_dst_ip,
    input  udp_port_t  buf_src_port,
    input  udp_port_t  buf_dst_port,
    input  udp_len_t   buf_length,
    output logic       stall,
    output logic       dec_valid,
    output data_t      dec_data,
    output keep_t      dec_keep,
    output logic       dec_last,
    output route_t     dec_route,
    output ipv4_addr_t dec_src_ip,
    output ipv4_addr_t dec_dst_ip,
    output udp_port_t  dec_src_port,
    output udp_port_t  dec_dst_port,
    output udp_len_t   dec_length,
    input  logic       exe_stall
);

    frame_state_t state;
    logic         take;

    // Hold the current beat while execute cannot accept it
    assign stall = dec_valid && exe_stall;
    assign take  = buf_valid && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= FRAME_HEAD;
            dec_valid <= 1'b0;
        end else begin
            if (!stall) begin
                dec_valid <= buf_valid;
            end
            if (take) begin
                state <= buf_last ? FRAME_HEAD : FRAME_BODY;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dec_data <= buf_data;
            dec_keep <= buf_keep;
            dec_last <= buf_last;
            // Route and header are fixed by the first beat of the frame
            if (state == FRAME_HEAD) begin
                dec_route    <= (buf_dst_port == ECHO_PORT) ? ROUTE_ECHO : ROUTE_USER;
                dec_src_ip   <= buf_src_ip;
                dec_dst_ip   <= buf_dst_ip;
                dec_src_port <= buf_src_port;
                dec_dst_port <= buf_dst_port;
                dec_length   <= buf_length;
            end
        end
    end

endmodule

//--- logic/udp_ingress_buffer.sv
`timescale 1ns/1ns

module udp_ingress_buffer import udp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  data_t      in_data,
    input  keep_t      in_keep,
    input  logic       in_last,
    input  ipv4_addr_t in_src_ip,
    input  ipv4_addr_t in_dst_ip,
    input  udp_port_t  in_src_port,
    input  udp_port_t  in_dst_port,
    input  udp_len_t   in_length,
    output logic       in_credit,
    output logic       buf_valid,
    output data_t      buf_data,
    output keep_t      buf_keep,
    output logic       buf_last,
    output ipv4_addr_t buf_src_ip,
    output ipv4_addr_t buf_dst_ip,
    output udp_port_t  buf_src_port,
    output udp_port_t  buf_dst_port,
    output udp_len_t   buf_length,
    input  logic       stall
);

    // Each entry keeps a beat together with its header
    data_t      mem_data     [IN_CREDITS];
    keep_t      mem_keep     [IN_CREDITS];
    logic       mem_last     [IN_CREDITS];
    ipv4_addr_t mem_src_ip   [IN_CREDITS];
    ipv4_addr_t mem_dst_ip   [IN_CREDITS];
    udp_port_t  mem_src_port [IN_CREDITS];
    udp_port_t  mem_dst_port [IN_CREDITS];
    udp_len_t   mem_length   [IN_CREDITS];

    logic [BUF_PTR_W-1:0] wr_ptr;
    logic [BUF_PTR_W-1:0] rd_ptr;
    logic [BUF_PTR_W:0]   count;

    assign buf_valid = (count != '0);

    // One credit goes back upstream for every beat that leaves
    assign in_credit = buf_valid && !stall;

    assign buf_data     = mem_data[rd_ptr];
    assign buf_keep     = mem_keep[rd_ptr];
    assign buf_last     = mem_last[rd_ptr];
    assign buf_src_ip   = mem_src_ip[rd_ptr];
    assign buf_dst_ip   = mem_dst_ip[rd_ptr];
    assign buf_src_port = mem_src_port[rd_ptr];
    assign buf_dst_port = mem_dst_port[rd_ptr];
    assign buf_length   = mem_length[rd_ptr];

    // Upstream credits guarantee a free entry, so every valid beat is written
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem_data[wr_ptr]     <= in_data;
            mem_keep[wr_ptr]     <= in_keep;
            mem_last[wr_ptr]     <= in_last;
            mem_src_ip[wr_ptr]   <= in_src_ip;
            mem_dst_ip[wr_ptr]   <= in_dst_ip;
            mem_src_port[wr_ptr] <= in_src_port;
            mem_dst_port[wr_ptr] <= in_dst_port;
            mem_length[wr_ptr]   <= in_length;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (in_credit) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + in_valid - in_credit;
        end
    end

endmodule

//--- logic/udp_pkg.sv
package udp_pkg;

    // Payload beat geometry
    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;

    // Ingress buffer depth, which is also the upstream credit count after reset
    localparam int IN_CREDITS = 4;
    localparam int BUF_PTR_W = $clog2(IN_CREDITS);

    // Output credit counters hold up to 15 outstanding credits
    localparam int CREDIT_W = 4;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [KEEP_W-1:0] keep_t;

    // UDP header fields
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // Frames to this port are looped back
    localparam udp_port_t ECHO_PORT = 16'd1234;

    typedef enum logic [0:0] {
        ROUTE_ECHO = 1'b0,
        ROUTE_USER = 1'b1
    } route_t;

    // HEAD expects the first beat of a frame
    typedef enum logic [0:0] {
        FRAME_HEAD = 1'b0,
        FRAME_BODY = 1'b1
    } frame_state_t;

endpackage
